// ==== src/scope_pkg.sv ====
//--------------------------------------
// digitizer command processor
// shared widths, types, command codes and constants
//--------------------------------------
`default_nettype none

package scope_pkg;

	//--------------------------------------
	// widths
	localparam int SAMPLE_W = 12;                   // one adc sample
	localparam int STROBE_W = 2;                    // one clock-strobe field
	localparam int SLOT_W   = STROBE_W + SAMPLE_W;  // stored slot with the strobe on top

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic [STROBE_W-1:0]        strobe_t;
	typedef logic [7:0]                 byte_t;
	typedef logic [31:0]                word_t;
	typedef logic [15:0]                frame_len_t;  // frames to take
	typedef logic [31:0]                byte_len_t;   // readout length in bytes

	// eight command bytes with op received first
	typedef struct packed {
		byte_t op;
		byte_t arg1;
		byte_t arg2;
		byte_t arg3;
		byte_t arg4;
		byte_t arg5;
		byte_t arg6;
		byte_t arg7;
	} cmd_t;

	typedef struct packed {
		logic       threshold;  // wait for the threshold crossing
		frame_len_t frames;
	} acq_cmd_t;

	typedef enum logic [7:0] {
		CMD_READOUT = 8'd0,
		CMD_VERSION = 8'd2,
		CMD_ARM     = 8'd5
	} cmd_op_e;

	//--------------------------------------
	// constants
	localparam word_t   FIRMWARE_VERSION = 32'd11;
	localparam sample_t TRIG_LOWER       = -12'sd10;
	localparam sample_t TRIG_UPPER       = 12'sd10;
	localparam word_t   FRAME_MARKER     = 32'hbeefdead;

endpackage

`default_nettype wire

// ==== src/cmd_receiver.sv ====
//--------------------------------------
// command receiver
// collects eight bytes from the command stream
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cmd_receiver
	import scope_pkg::*;
(
	input  wire        clk,
	input  wire        rstn,
	input  wire        i_tvalid,
	input  wire byte_t i_tdata,
	output logic       o_tready,
	output cmd_t       o_cmd,
	output logic       o_cmd_valid,
	input  wire        i_cmd_take
);

	logic [2:0] byte_cnt;
	logic       accept;

	assign o_tready = !o_cmd_valid;  // stall while a command is pending
	assign accept   = i_tvalid && o_tready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt    <= '0;
			o_cmd_valid <= 1'b0;
		end else if (accept) begin
			byte_cnt <= byte_cnt + 3'd1;  // wraps after the eighth byte
			if (byte_cnt == 3'd7) begin
				o_cmd_valid <= 1'b1;
			end
		end else if (i_cmd_take) begin
			o_cmd_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			case (byte_cnt)
				3'd0: o_cmd.op   <= i_tdata;
				3'd1: o_cmd.arg1 <= i_tdata;
				3'd2: o_cmd.arg2 <= i_tdata;
				3'd3: o_cmd.arg3 <= i_tdata;
				3'd4: o_cmd.arg4 <= i_tdata;
				3'd5: o_cmd.arg5 <= i_tdata;
				3'd6: o_cmd.arg6 <= i_tdata;
				default: o_cmd.arg7 <= i_tdata;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/cmd_processor.sv ====
//--------------------------------------
// command processor
// decodes a received command, arms the acquisition
// or requests a reply and waits for it to finish
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cmd_processor
	import scope_pkg::*;
(
	input  wire       clk,
	input  wire       rstn,
	input  wire cmd_t i_cmd,
	input  wire       i_cmd_valid,
	output logic      o_cmd_take,
	input  wire       i_acq_idle,
	output logic      o_arm,
	output acq_cmd_t  o_acq_cmd,
	output logic      o_const_req,
	output word_t     o_const_word,
	output logic      o_dump_req,
	output byte_len_t o_dump_len,
	input  wire       i_reply_done
);

	typedef enum logic {
		IDLE,
		WAIT_REPLY
	} proc_state_e;

	proc_state_e state;
	logic        start;

	// cmd_valid is still high in the cycle of the take pulse
	assign start = i_cmd_valid && !o_cmd_take && (state == IDLE);

	//--------------------------------------
	// control
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= IDLE;
			o_cmd_take  <= 1'b0;
			o_arm       <= 1'b0;
			o_const_req <= 1'b0;
			o_dump_req  <= 1'b0;
		end else begin
			o_cmd_take  <= start;
			o_arm       <= 1'b0;
			o_const_req <= 1'b0;
			o_dump_req  <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						case (i_cmd.op)
							CMD_READOUT: begin
								o_dump_req <= 1'b1;
								state      <= WAIT_REPLY;
							end
							CMD_VERSION: begin
								o_const_req <= 1'b1;
								state       <= WAIT_REPLY;
							end
							CMD_ARM: begin
								o_arm <= i_acq_idle;  // dropped while a capture runs
							end
							default: ;  // unknown code gets no reply
						endcase
					end
				end
				WAIT_REPLY: begin
					if (i_reply_done) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	//--------------------------------------
	// request payloads, sampled with the command
	always_ff @(posedge clk) begin
		if (start) begin
			o_dump_len          <= {i_cmd.arg7, i_cmd.arg6, i_cmd.arg5, i_cmd.arg4};
			o_const_word        <= FIRMWARE_VERSION;
			o_acq_cmd.threshold <= (i_cmd.arg1 == 8'd1);
			o_acq_cmd.frames    <= {i_cmd.arg5, i_cmd.arg4};  // little endian
		end
	end

endmodule

`default_nettype wire

// ==== src/sample_unpack.sv ====
//--------------------------------------
// sample unpacker
// de-interleaves the raw lane bits into samples and strobes
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_unpack
	import scope_pkg::*;
#(
	parameter int NUM_SAMPLES = 8
) (
	input  wire                            clk,
	input  wire                            rstn,
	input  wire [NUM_SAMPLES*SLOT_W-1:0]   i_lvds_bits,
	output sample_t [NUM_SAMPLES-1:0]      o_samples,
	output strobe_t [NUM_SAMPLES-1:0]      o_strobes
);

	sample_t [NUM_SAMPLES-1:0] samples_d;
	strobe_t [NUM_SAMPLES-1:0] strobes_d;

	// bit b of sample k sits at NUM_SAMPLES*b + k with the strobe bits above
	always_comb begin
		for (int k = 0; k < NUM_SAMPLES; k++) begin
			for (int b = 0; b < SAMPLE_W; b++) begin
				samples_d[k][b] = i_lvds_bits[NUM_SAMPLES*b + k];
			end
			for (int s = 0; s < STROBE_W; s++) begin
				strobes_d[k][s] = i_lvds_bits[NUM_SAMPLES*(SAMPLE_W+s) + k];
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_samples <= '0;
			o_strobes <= '0;
		end else begin
			o_samples <= samples_d;
			o_strobes <= strobes_d;
		end
	end

endmodule

`default_nettype wire

// ==== src/acq_trigger.sv ====
//--------------------------------------
// acquisition control
// optional threshold trigger on sample 0, then writes
// one packed frame per cycle into the sample fifo
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module acq_trigger
	import scope_pkg::*;
#(
	parameter int NUM_SAMPLES = 8
) (
	input  wire                              clk,
	input  wire                              rstn,
	input  wire                              i_arm,
	input  wire acq_cmd_t                    i_acq_cmd,
	output logic                             o_idle,
	input  wire sample_t [NUM_SAMPLES-1:0]   i_samples,
	input  wire strobe_t [NUM_SAMPLES-1:0]   i_strobes,
	output logic                             o_wr,
	output logic [NUM_SAMPLES*SLOT_W-1:0]    o_wr_frame,
	input  wire                              i_full
);

	typedef enum logic [1:0] {
		READY,
		WAIT_LOW,
		WAIT_HIGH,
		TAKE
	} acq_state_e;

	acq_state_e state;
	frame_len_t frame_cnt;
	frame_len_t frame_target;

	assign o_idle = (state == READY);
	assign o_wr   = (state == TAKE) && !i_full && (frame_cnt < frame_target);

	// slot k holds strobe k above sample k
	always_comb begin
		for (int k = 0; k < NUM_SAMPLES; k++) begin
			o_wr_frame[k*SLOT_W +: SLOT_W] = {i_strobes[k], i_samples[k]};
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state        <= READY;
			frame_cnt    <= '0;
			frame_target <= '0;
		end else begin
			case (state)
				READY: begin
					if (i_arm) begin
						frame_cnt    <= '0;
						frame_target <= i_acq_cmd.frames;
						if (i_acq_cmd.threshold) begin
							state <= WAIT_LOW;
						end else begin
							state <= TAKE;  // untriggered capture
						end
					end
				end
				WAIT_LOW: begin
					if ($signed(i_samples[0]) < TRIG_LOWER) state <= WAIT_HIGH;
				end
				WAIT_HIGH: begin
					if ($signed(i_samples[0]) > TRIG_UPPER) state <= TAKE;
				end
				TAKE: begin
					if (o_wr) begin
						frame_cnt <= frame_cnt + 16'd1;
					end else begin
						state <= READY;  // count reached or fifo full
					end
				end
				default: state <= READY;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/sample_fifo.sv ====
//--------------------------------------
// sample fifo
// show-ahead frame buffer between capture and readout
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_fifo
	import scope_pkg::*;
#(
	parameter int NUM_SAMPLES = 8,
	parameter int FIFO_DEPTH  = 16
) (
	input  wire                            clk,
	input  wire                            rstn,
	input  wire                            i_wr,
	input  wire [NUM_SAMPLES*SLOT_W-1:0]   i_wr_frame,
	output logic                           o_full,
	input  wire                            i_rd,
	output logic [NUM_SAMPLES*SLOT_W-1:0]  o_rd_frame,
	output logic                           o_empty
);

	localparam int FRAME_W = NUM_SAMPLES * SLOT_W;
	localparam int AW      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW      = $clog2(FIFO_DEPTH + 1);

	logic [FRAME_W-1:0] mem [FIFO_DEPTH];
	logic [AW-1:0]      wr_ptr;
	logic [AW-1:0]      rd_ptr;
	logic [CW-1:0]      count;
	logic               wr_en;
	logic               rd_en;

	assign wr_en      = i_wr && !o_full;
	assign rd_en      = i_rd && !o_empty;
	assign o_full     = (count == CW'(FIFO_DEPTH));
	assign o_empty    = (count == '0);
	assign o_rd_frame = mem[rd_ptr];  // head of queue

	always_ff @(posedge clk) begin
		if (wr_en) mem[wr_ptr] <= i_wr_frame;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en) rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CW'(wr_en) - CW'(rd_en);
		end
	end

endmodule

`default_nettype wire

// ==== src/reply_tx.sv ====
//--------------------------------------
// reply transmitter
// drives the 32-bit reply stream, either one constant
// word or frames popped from the sample fifo
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reply_tx
	import scope_pkg::*;
#(
	parameter int NUM_SAMPLES = 8
) (
	input  wire                            clk,
	input  wire                            rstn,
	input  wire                            i_const_req,
	input  wire word_t                     i_const_word,
	input  wire                            i_dump_req,
	input  wire byte_len_t                 i_dump_len,
	output logic                           o_done,
	input  wire [NUM_SAMPLES*SLOT_W-1:0]   i_rd_frame,
	input  wire                            i_empty,
	output logic                           o_rd,
	output logic                           o_tvalid,
	output word_t                          o_tdata,
	output logic [3:0]                     o_tkeep,
	output logic                           o_tlast,
	input  wire                            i_tready
);

	localparam int HALF  = NUM_SAMPLES / 2;
	localparam int WPF   = HALF + 2;  // pairs, strobe word, marker
	localparam int IDX_W = $clog2(WPF);

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		SEND
	} tx_state_e;

	tx_state_e                   state;
	logic                        const_mode;
	word_t                       const_q;
	logic [NUM_SAMPLES*SLOT_W-1:0] frame_q;
	logic [IDX_W-1:0]            word_idx;
	byte_len_t                   words_left;
	byte_len_t                   dump_words;
	logic [3:0]                  keep_last;
	word_t                       strobe_word;
	word_t                       frame_word;

	assign dump_words = {2'b00, i_dump_len[31:2]} + byte_len_t'(|i_dump_len[1:0]);
	assign o_rd       = (state == FETCH) && !i_empty;
	assign o_tvalid   = (state == SEND);
	assign o_tlast    = (words_left == 32'd1);
	assign o_tkeep    = o_tlast ? keep_last : 4'b1111;
	assign o_tdata    = const_mode ? const_q : frame_word;

	//--------------------------------------
	// word layout within a frame
	always_comb begin
		strobe_word = '0;
		for (int k = 0; k < NUM_SAMPLES; k++) begin
			strobe_word[k*STROBE_W +: STROBE_W] = frame_q[k*SLOT_W + SAMPLE_W +: STROBE_W];
		end
		if (word_idx < IDX_W'(HALF)) begin
			frame_word = {4'b0, frame_q[(2*word_idx+1)*SLOT_W +: SAMPLE_W],
				4'b0, frame_q[(2*word_idx)*SLOT_W +: SAMPLE_W]};
		end else if (word_idx == IDX_W'(HALF)) begin
			frame_word = strobe_word;
		end else begin
			frame_word = FRAME_MARKER;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= IDLE;
			o_done     <= 1'b0;
			const_mode <= 1'b0;
			word_idx   <= '0;
			words_left <= '0;
			keep_last  <= 4'b1111;
		end else begin
			o_done <= 1'b0;
			case (state)
				IDLE: begin
					if (i_const_req) begin
						const_mode <= 1'b1;
						words_left <= 32'd1;
						keep_last  <= 4'b1111;
						state      <= SEND;
					end else if (i_dump_req) begin
						const_mode <= 1'b0;
						words_left <= dump_words;
						case (i_dump_len[1:0])  // bytes in the last word
							2'd1:    keep_last <= 4'b0001;
							2'd2:    keep_last <= 4'b0011;
							2'd3:    keep_last <= 4'b0111;
							default: keep_last <= 4'b1111;
						endcase
						if (dump_words == '0) o_done <= 1'b1;  // nothing to send
						else state <= FETCH;
					end
				end
				FETCH: begin
					if (o_rd) begin
						word_idx <= '0;
						state    <= SEND;
					end
				end
				SEND: begin
					if (i_tready) begin
						words_left <= words_left - 32'd1;
						if (o_tlast) begin
							o_done <= 1'b1;
							state  <= IDLE;
						end else if (word_idx == IDX_W'(WPF-1)) begin
							state <= FETCH;  // next frame
						end else begin
							word_idx <= word_idx + 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_const_req && state == IDLE) const_q <= i_const_word;
		if (o_rd) frame_q <= i_rd_frame;
	end

endmodule

`default_nettype wire

// ==== src/scope_top.sv ====
//--------------------------------------
// digitizer command processor top level
// command stream in, acquisition into fifo, reply stream out
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scope_top
	import scope_pkg::*;
#(
	parameter int NUM_SAMPLES = 8,   // even, at most 16
	parameter int FIFO_DEPTH  = 16
) (
	input  wire                            clk,
	input  wire                            rstn,
	// command stream
	input  wire                            i_s_tvalid,
	input  wire byte_t                     i_s_tdata,
	output logic                           o_s_tready,
	// reply stream
	output logic                           o_m_tvalid,
	output word_t                          o_m_tdata,
	output logic [3:0]                     o_m_tkeep,
	output logic                           o_m_tlast,
	input  wire                            i_m_tready,
	// raw lane bits
	input  wire [NUM_SAMPLES*SLOT_W-1:0]   i_lvds_bits
);

	localparam int FRAME_W = NUM_SAMPLES * SLOT_W;

	cmd_t      cmd;
	logic      cmd_valid;
	logic      cmd_take;
	logic      acq_idle;
	logic      arm;
	acq_cmd_t  acq_cmd;
	logic      const_req;
	word_t     const_word;
	logic      dump_req;
	byte_len_t dump_len;
	logic      reply_done;

	sample_t [NUM_SAMPLES-1:0] samples;
	strobe_t [NUM_SAMPLES-1:0] strobes;
	logic                      wr;
	logic [FRAME_W-1:0]        wr_frame;
	logic                      full;
	logic                      rd;
	logic [FRAME_W-1:0]        rd_frame;
	logic                      empty;

	//--------------------------------------
	// command path
	cmd_receiver rx_i (
		.clk(clk), .rstn(rstn),
		.i_tvalid(i_s_tvalid), .i_tdata(i_s_tdata), .o_tready(o_s_tready),
		.o_cmd(cmd), .o_cmd_valid(cmd_valid), .i_cmd_take(cmd_take)
	);

	cmd_processor proc_i (
		.clk(clk), .rstn(rstn),
		.i_cmd(cmd), .i_cmd_valid(cmd_valid), .o_cmd_take(cmd_take),
		.i_acq_idle(acq_idle), .o_arm(arm), .o_acq_cmd(acq_cmd),
		.o_const_req(const_req), .o_const_word(const_word),
		.o_dump_req(dump_req), .o_dump_len(dump_len), .i_reply_done(reply_done)
	);

	//--------------------------------------
	// capture path
	sample_unpack #(.NUM_SAMPLES(NUM_SAMPLES)) unpack_i (
		.clk(clk), .rstn(rstn), .i_lvds_bits(i_lvds_bits),
		.o_samples(samples), .o_strobes(strobes)
	);

	acq_trigger #(.NUM_SAMPLES(NUM_SAMPLES)) trig_i (
		.clk(clk), .rstn(rstn), .i_arm(arm), .i_acq_cmd(acq_cmd), .o_idle(acq_idle),
		.i_samples(samples), .i_strobes(strobes),
		.o_wr(wr), .o_wr_frame(wr_frame), .i_full(full)
	);

	sample_fifo #(.NUM_SAMPLES(NUM_SAMPLES), .FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
		.clk(clk), .rstn(rstn),
		.i_wr(wr), .i_wr_frame(wr_frame), .o_full(full),
		.i_rd(rd), .o_rd_frame(rd_frame), .o_empty(empty)
	);

	//--------------------------------------
	// reply path
	reply_tx #(.NUM_SAMPLES(NUM_SAMPLES)) tx_i (
		.clk(clk), .rstn(rstn),
		.i_const_req(const_req), .i_const_word(const_word),
		.i_dump_req(dump_req), .i_dump_len(dump_len), .o_done(reply_done),
		.i_rd_frame(rd_frame), .i_empty(empty), .o_rd(rd),
		.o_tvalid(o_m_tvalid), .o_tdata(o_m_tdata), .o_tkeep(o_m_tkeep),
		.o_tlast(o_m_tlast), .i_tready(i_m_tready)
	);

endmodule

`default_nettype wire

// ==== tb/scope_asserts.sv ====
//--------------------------------------
// reply stream protocol checks
// bound to the digitizer top level
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scope_asserts
	import scope_pkg::*;
(
	input wire        clk,
	input wire        rstn,
	input wire        o_m_tvalid,
	input wire word_t o_m_tdata,
	input wire [3:0]  o_m_tkeep,
	input wire        o_m_tlast,
	input wire        i_m_tready
);

	int fail_cnt = 0;  // read by the testbench

	//--------------------------------------
	// stream rules
	property p_hold_on_stall;
		@(posedge clk) disable iff (!rstn)
		o_m_tvalid && !i_m_tready |=> o_m_tvalid && $stable(o_m_tdata)
			&& $stable(o_m_tkeep) && $stable(o_m_tlast);
	endproperty

	property p_keep_nonzero;
		@(posedge clk) disable iff (!rstn)
		o_m_tvalid |-> (o_m_tkeep != 4'b0000);
	endproperty

	property p_idle_after_reset;
		@(posedge clk) $rose(rstn) |-> !o_m_tvalid;
	endproperty

	a_hold_on_stall: assert property (p_hold_on_stall)
		else begin
			$error("reply word changed or dropped while tready was low");
			fail_cnt++;
		end

	a_keep_nonzero: assert property (p_keep_nonzero)
		else begin
			$error("reply word sent with an empty tkeep");
			fail_cnt++;
		end

	a_idle_after_reset: assert property (p_idle_after_reset)
		else begin
			$error("tvalid high right after reset release");
			fail_cnt++;
		end

endmodule

`default_nettype wire

// ==== tb/scope_tb.sv ====
//--------------------------------------
// testbench for the digitizer command processor
// commands, capture, readout and reply checks
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scope_tb
	import scope_pkg::*;
();

	localparam int NS      = 8;
	localparam int DEPTH   = 16;
	localparam int WPF     = NS / 2 + 2;  // pair words, strobe word, marker
	localparam int TIMEOUT = 2000;

	typedef logic [NS*SLOT_W-1:0] lane_t;

	logic       clk         = 1'b0;
	logic       rstn        = 1'b0;
	logic       i_s_tvalid  = 1'b0;
	byte_t      i_s_tdata   = '0;
	logic       o_s_tready;
	logic       o_m_tvalid;
	word_t      o_m_tdata;
	logic [3:0] o_m_tkeep;
	logic       o_m_tlast;
	logic       i_m_tready  = 1'b0;
	lane_t      i_lvds_bits = '0;

	integer     seed      = 32'hc735;
	logic [7:0] gen_cnt   = '0;    // frame tag of the lane generator
	logic       trig_mode = 1'b0;
	sample_t    trig_s0   = '0;

	word_t      rx_data[$];
	logic [3:0] rx_keep[$];
	logic       rx_last[$];
	int         stall_cnt  = 0;
	int         stall_mark = 0;
	int         errors     = 0;
	int         err_mark   = 0;
	int         tests_run  = 0;
	int         tests_bad  = 0;

	scope_top #(.NUM_SAMPLES(NS), .FIFO_DEPTH(DEPTH)) dut_i (
		.clk(clk), .rstn(rstn),
		.i_s_tvalid(i_s_tvalid), .i_s_tdata(i_s_tdata), .o_s_tready(o_s_tready),
		.o_m_tvalid(o_m_tvalid), .o_m_tdata(o_m_tdata), .o_m_tkeep(o_m_tkeep),
		.o_m_tlast(o_m_tlast), .i_m_tready(i_m_tready),
		.i_lvds_bits(i_lvds_bits)
	);

	bind scope_top scope_asserts asserts_i (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		i_m_tready <= ($random(seed) & 3) != 0;  // about one stall in four
	end

	//--------------------------------------
	// reference model
	// count frame n holds sample k = 16n + k and strobe k = n + k
	// a trigger frame holds the given sample 0, sample k = 100 + k and strobe k = k
	function automatic void make_frame(input int n, input logic trig, input sample_t s0,
		output sample_t s [NS], output strobe_t st [NS]);
		for (int k = 0; k < NS; k++) begin
			if (trig) begin
				s[k]  = (k == 0) ? s0 : sample_t'(100 + k);
				st[k] = strobe_t'(k);
			end else begin
				s[k]  = sample_t'((n & 255) * 16 + k);
				st[k] = strobe_t'(n + k);
			end
		end
	endfunction

	// bit b of sample k at NS*b + k and strobe bits above all sample bits
	function automatic lane_t encode_lanes(input sample_t s [NS], input strobe_t st [NS]);
		lane_t r;
		r = '0;
		for (int k = 0; k < NS; k++) begin
			for (int b = 0; b < SAMPLE_W; b++) begin
				r[NS*b + k] = s[k][b];
			end
			r[NS*SAMPLE_W + k]     = st[k][0];
			r[NS*(SAMPLE_W+1) + k] = st[k][1];
		end
		return r;
	endfunction

	function automatic word_t pack_word(input sample_t s [NS], input strobe_t st [NS],
		input int w);
		word_t r;
		r = '0;
		if (w < NS / 2) begin
			r = {4'b0, s[2*w+1], 4'b0, s[2*w]};
		end else if (w == NS / 2) begin
			for (int k = 0; k < NS; k++) begin
				r[2*k +: 2] = st[k];
			end
		end else begin
			r = 32'hbeefdead;
		end
		return r;
	endfunction

	function automatic cmd_t make_cmd(input byte_t op, input byte_t arg1, input word_t val);
		return {op, arg1, 16'h0, val[7:0], val[15:8], val[23:16], val[31:24]};
	endfunction

	always @(posedge clk) begin : lane_gen
		sample_t s [NS];
		strobe_t st [NS];
		make_frame(gen_cnt, trig_mode, trig_s0, s, st);
		i_lvds_bits <= encode_lanes(s, st);
		gen_cnt     <= gen_cnt + 8'd1;
	end

	// accepted words are captured half a cycle before the edge that takes them
	always @(negedge clk) begin
		if (rstn && o_m_tvalid) begin
			if (i_m_tready) begin
				rx_data.push_back(o_m_tdata);
				rx_keep.push_back(o_m_tkeep);
				rx_last.push_back(o_m_tlast);
			end else begin
				stall_cnt++;
			end
		end
	end

	//--------------------------------------
	// helpers
	task automatic send_cmd(input cmd_t c);
		int t;
		@(posedge clk);
		for (int i = 0; i < 8; i++) begin
			i_s_tvalid <= 1'b1;
			i_s_tdata  <= c[63-8*i -: 8];
			t = 0;
			@(negedge clk);
			while (!o_s_tready && t < TIMEOUT) begin
				@(negedge clk);
				t++;
			end
			if (!o_s_tready) begin
				$display("command byte %0d was never accepted", i);
				errors++;
			end
			@(posedge clk);
		end
		i_s_tvalid <= 1'b0;
	endtask

	task automatic wait_words(input string name, input int n);
		int t;
		t = 0;
		while (rx_data.size() < n && t < TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		repeat (20) @(posedge clk);  // quiet window for stray words
		if (rx_data.size() < n) begin
			$display("%s: timed out with %0d of %0d reply words", name, rx_data.size(), n);
			errors++;
		end else if (rx_data.size() != n) begin
			$display("mismatch %s word count: expected %0d, actual %0d",
				name, n, rx_data.size());
			errors++;
		end
	endtask

	task automatic check_value(input string label, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("mismatch %s: expected %h, actual %h", label, exp, act);
			errors++;
		end
	endtask

	task automatic start_test();
		tests_run++;
		err_mark = errors;
		rx_data.delete();
		rx_keep.delete();
		rx_last.delete();
	endtask

	task automatic finish_test(input string name);
		if (errors == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: failed with %0d errors", name, errors - err_mark);
		end
	endtask

	task automatic check_const(input string name, input word_t exp);
		wait_words(name, 1);
		if (rx_data.size() > 0) begin
			check_value({name, " data"}, exp, rx_data[0]);
			check_value({name, " keep"}, 4'b1111, rx_keep[0]);
			check_value({name, " last"}, 1, rx_last[0]);
		end
	endtask

	// expects one trigger frame when trig is set and consecutive count frames otherwise
	task automatic check_dump(input string name, input int nbytes, input logic trig);
		int         nw;
		int         n;
		logic [3:0] keep_exp;
		sample_t    s0;
		sample_t    s [NS];
		strobe_t    st [NS];
		nw       = (nbytes + 3) / 4;
		keep_exp = (nbytes % 4 == 0) ? 4'b1111 : 4'((1 << (nbytes % 4)) - 1);
		wait_words(name, nw);
		if (rx_data.size() == nw) begin
			n  = rx_data[0][11:4];  // frame tag from sample 0
			s0 = rx_data[0][11:0];
			if (trig && s0 <= 12'sd10) begin
				$display("mismatch %s sample 0: expected above 10, actual %0d", name, s0);
				errors++;
			end
			for (int i = 0; i < nw; i++) begin
				make_frame(n + i / WPF, trig, s0, s, st);
				check_value($sformatf("%s word %0d", name, i), pack_word(s, st, i % WPF),
					rx_data[i]);
				check_value($sformatf("%s last %0d", name, i), i == nw - 1, rx_last[i]);
				if (i == nw - 1) begin
					check_value({name, " keep"}, keep_exp, rx_keep[i]);
				end
			end
		end
	endtask

	//--------------------------------------
	// test sequence
	initial begin
		repeat (5) @(posedge clk);
		rstn <= 1'b1;
		repeat (3) @(posedge clk);

		start_test();
		send_cmd(make_cmd(8'd2, 8'd0, 32'd0));
		check_const("version", 32'd11);
		finish_test("version");

		start_test();
		send_cmd(make_cmd(8'd9, 8'd0, 32'd0));
		repeat (50) @(posedge clk);
		if (rx_data.size() != 0) begin
			$display("mismatch unknown_cmd reply count: expected 0, actual %0d",
				rx_data.size());
			errors++;
		end
		send_cmd(make_cmd(8'd2, 8'd0, 32'd0));
		check_const("unknown_cmd", 32'd11);
		finish_test("unknown_cmd");

		stall_mark = stall_cnt;
		start_test();
		send_cmd(make_cmd(8'd5, 8'd0, 32'd3));            // untriggered capture of 3 frames
		send_cmd(make_cmd(8'd0, 8'd0, 32'(3 * WPF * 4)));
		check_dump("capture", 3 * WPF * 4, 1'b0);
		finish_test("capture");

		start_test();
		@(posedge clk);
		trig_mode <= 1'b1;
		trig_s0   <= 12'sd0;
		repeat (10) @(posedge clk);
		send_cmd(make_cmd(8'd5, 8'd1, 32'd1));            // threshold mode for 1 frame
		repeat (10) @(posedge clk);
		trig_s0 <= -12'sd20;
		repeat (5) @(posedge clk);
		for (int i = 0; i < 30; i++) begin
			@(posedge clk);
			trig_s0 <= sample_t'(21 + i);                 // ramp above the upper threshold
		end
		send_cmd(make_cmd(8'd0, 8'd0, 32'(WPF * 4)));
		check_dump("trigger", WPF * 4, 1'b1);
		finish_test("trigger");

		start_test();
		@(posedge clk);
		trig_mode <= 1'b0;
		send_cmd(make_cmd(8'd5, 8'd0, 32'd2));
		send_cmd(make_cmd(8'd0, 8'd0, 32'd30));           // 4*7 + 2 bytes
		check_dump("partial", 30, 1'b0);
		finish_test("partial");

		start_test();
		if (stall_cnt == stall_mark) begin
			$display("no tready stall happened during readout");
			errors++;
		end
		if (dut_i.asserts_i.fail_cnt != 0) begin
			$display("%0d protocol assertions failed", dut_i.asserts_i.fail_cnt);
			errors++;
		end
		finish_test("backpressure");

		$display("tests: %0d run, %0d failed, %0d errors, %0d assertion failures",
			tests_run, tests_bad, errors, dut_i.asserts_i.fail_cnt);
		if (tests_bad == 0 && dut_i.asserts_i.fail_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
src/scope_pkg.sv
src/cmd_receiver.sv
src/cmd_processor.sv
src/sample_unpack.sv
src/acq_trigger.sv
src/sample_fifo.sv
src/reply_tx.sv
src/scope_top.sv
tb/scope_asserts.sv
tb/scope_tb.sv
